// ==== design/bus_pkg.sv ====
package bus_pkg;

  // one queued access as it arrives from outside
  typedef struct packed {
    logic [31:0] address;
    logic [31:0] write_data;
    logic        write;       // 0 = read
  } bus_request_t;

  typedef enum logic [3:0] {
    cs_none       = 4'd0,
    cs_vectors    = 4'd1,
    cs_rom        = 4'd2,
    cs_mandelbrot = 4'd3,
    cs_io         = 4'd4,
    cs_led        = 4'd5,
    cs_ssram      = 4'd6,
    cs_sdram      = 4'd7,
    cs_flash      = 4'd8
  } chip_select_t;

  typedef enum logic [1:0] {
    fault_none,
    fault_bus,    // misaligned
    fault_page,   // unmapped
    fault_write   // write to read-only region
  } fault_t;

  typedef struct packed {
    logic [31:0] address;
    logic [31:0] write_data;
    logic        start;       // high in START only
    logic        buswrite;    // high in PRE for an unfaulted write
  } bus_cycle_t;

  typedef struct packed {
    logic [31:0] read_data;
    fault_t      fault;
  } bus_response_t;

  // region map, inclusive bounds
  localparam logic [31:0] ssram_base      = 32'h0000_0000;
  localparam logic [31:0] ssram_limit     = 32'h003f_ffff;
  localparam logic [31:0] led_base        = 32'h0080_0000;
  localparam logic [31:0] led_limit       = 32'h0080_07ff;
  localparam logic [31:0] io_base         = 32'h0080_0800;
  localparam logic [31:0] io_limit        = 32'h0080_0fff;
  localparam logic [31:0] sdram_base      = 32'hc000_0000;
  localparam logic [31:0] sdram_limit     = 32'hcfff_ffff;
  localparam logic [31:0] mandelbrot_base = 32'hd000_0000;
  localparam logic [31:0] mandelbrot_limit = 32'hdfff_ffff;
  localparam logic [31:0] flash_base      = 32'he000_0000;
  localparam logic [31:0] flash_limit     = 32'hefff_ffff;
  localparam logic [31:0] rom_base        = 32'hffff_0000;
  localparam logic [31:0] rom_limit       = 32'hffff_ffbf;
  localparam logic [31:0] vectors_base    = 32'hffff_ffc0;
  localparam logic [31:0] vectors_limit   = 32'hffff_ffff;

endpackage

// ==== design/request_fifo.sv ====
`timescale 1ns/10ps

module request_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  push,
  input  bus_pkg::bus_request_t request,
  input  logic                  pop,
  output bus_pkg::bus_request_t head,
  output logic                  present,
  output logic                  full
);

  localparam int pointer_bits = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int count_bits = $clog2(fifo_depth + 1);

  bus_pkg::bus_request_t   entries [fifo_depth];
  logic [pointer_bits-1:0] write_pointer;
  logic [pointer_bits-1:0] read_pointer;
  logic [count_bits-1:0]   count;
  logic                    do_push;
  logic                    do_pop;

  // wrap at fifo_depth, which need not be a power of two
  function automatic logic [pointer_bits-1:0] advance(input logic [pointer_bits-1:0] pointer);
    logic [pointer_bits-1:0] next;
    if (pointer == pointer_bits'(fifo_depth - 1)) begin
      next = '0;
    end else begin
      next = pointer + 1'b1;
    end
    return next;
  endfunction

  assign present = (count != '0);
  assign full    = (count == count_bits'(fifo_depth));
  assign head    = entries[read_pointer];  // head shown without a register stage
  assign do_push = push && !full;
  assign do_pop  = pop && present;

  always_ff @(posedge clock) begin
    if (do_push) begin
      entries[write_pointer] <= request;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      write_pointer <= '0;
      read_pointer  <= '0;
      count         <= '0;
    end else begin
      if (do_push) begin
        write_pointer <= advance(write_pointer);
      end
      if (do_pop) begin
        read_pointer <= advance(read_pointer);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // both or neither
      endcase
    end
  end

  // producer must respect full, mmu must respect present
  assert property (@(posedge clock) disable iff (!reset_n) push |-> !full);
  assert property (@(posedge clock) disable iff (!reset_n) pop |-> present);

endmodule

// ==== design/mmu.sv ====
`timescale 1ns/10ps

module mmu (
  input  logic                   clock,
  input  logic                   reset_n,
  input  bus_pkg::bus_request_t  head,
  input  logic                   present,
  input  logic [31:0]            read_data,
  output logic                   pop,
  output bus_pkg::chip_select_t  chipselect,
  output bus_pkg::bus_cycle_t    bus,
  output logic                   buswait,
  output logic                   response_valid,
  output bus_pkg::bus_response_t response
);

  typedef enum logic [1:0] {
    state_idle,
    state_start,  // request held
    state_pre,    // read or write cycle
    state_post    // data visible
  } state_t;

  state_t                state;
  state_t                state_next;
  bus_pkg::bus_request_t latched;
  bus_pkg::chip_select_t cs;
  bus_pkg::fault_t       fault;
  logic                  data_region;

  // prioritized range check with the lowest regions first
  function automatic bus_pkg::chip_select_t decode(input logic [31:0] address);
    bus_pkg::chip_select_t region;
    if (address >= bus_pkg::ssram_base && address <= bus_pkg::ssram_limit) begin
      region = bus_pkg::cs_ssram;
    end else if (address >= bus_pkg::led_base && address <= bus_pkg::led_limit) begin
      region = bus_pkg::cs_led;
    end else if (address >= bus_pkg::io_base && address <= bus_pkg::io_limit) begin
      region = bus_pkg::cs_io;
    end else if (address >= bus_pkg::sdram_base && address <= bus_pkg::sdram_limit) begin
      region = bus_pkg::cs_sdram;
    end else if (address >= bus_pkg::mandelbrot_base &&
                 address <= bus_pkg::mandelbrot_limit) begin
      region = bus_pkg::cs_mandelbrot;
    end else if (address >= bus_pkg::flash_base && address <= bus_pkg::flash_limit) begin
      region = bus_pkg::cs_flash;
    end else if (address >= bus_pkg::rom_base && address <= bus_pkg::rom_limit) begin
      region = bus_pkg::cs_rom;
    end else if (address >= bus_pkg::vectors_base && address <= bus_pkg::vectors_limit) begin
      region = bus_pkg::cs_vectors;
    end else begin
      region = bus_pkg::cs_none;
    end
    return region;
  endfunction

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= state_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (state == state_idle && present) begin
      latched <= head;  // held from START through POST
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      state_idle:  state_next = present ? state_start : state_idle;
      state_start: state_next = present ? state_pre : state_idle;
      state_pre:   state_next = state_post;
      state_post:  state_next = state_idle;
      default:     state_next = state_idle;
    endcase
  end

  assign cs = decode(latched.address);

  // misaligned beats unmapped beats read-only
  always_comb begin
    if (latched.address[1:0] != 2'b00) begin
      fault = bus_pkg::fault_bus;
    end else if (cs == bus_pkg::cs_none) begin
      fault = bus_pkg::fault_page;
    end else if (latched.write && (cs == bus_pkg::cs_rom || cs == bus_pkg::cs_vectors)) begin
      fault = bus_pkg::fault_write;
    end else begin
      fault = bus_pkg::fault_none;
    end
  end

  // a faulted access selects no target, so nothing is read or written
  assign chipselect = (present && state != state_idle && fault == bus_pkg::fault_none) ?
                      cs : bus_pkg::cs_none;

  assign bus.address    = latched.address;
  assign bus.write_data = latched.write_data;
  assign bus.start      = (state == state_start);
  assign bus.buswrite   = (state == state_pre) && latched.write &&
                          (fault == bus_pkg::fault_none);

  assign buswait        = (state != state_post);
  assign response_valid = (state == state_post);
  assign pop            = (state == state_post);

  assign data_region = (cs == bus_pkg::cs_ssram) || (cs == bus_pkg::cs_io);

  // writes and unmodeled regions answer zero
  assign response.read_data = (response_valid && !latched.write && data_region &&
                               fault == bus_pkg::fault_none) ? read_data : 32'h0;
  assign response.fault     = response_valid ? fault : bus_pkg::fault_none;

  assert property (@(posedge clock) disable iff (!reset_n)
    pop |-> present);  // fifo head must be valid when removed

endmodule

// ==== design/memory_targets.sv ====
`timescale 1ns/10ps

module memory_targets #(
  parameter int sram_words = 64
) (
  input  logic                  clock,
  input  logic                  reset_n,
  input  bus_pkg::chip_select_t chipselect,
  input  bus_pkg::bus_cycle_t   bus,
  output logic [31:0]           read_data
);

  localparam int index_bits = $clog2(sram_words);

  logic [31:0]           sram [sram_words];
  logic [31:0]           io_regs [8];
  logic [index_bits-1:0] sram_index;
  logic [2:0]            io_index;
  logic                  sram_sel;
  logic                  io_sel;
  logic                  access_phase;  // PRE, one cycle after start

  assign sram_index = bus.address[index_bits+1:2];  // word address wraps at sram_words
  assign io_index   = bus.address[4:2];
  assign sram_sel   = (chipselect == bus_pkg::cs_ssram);
  assign io_sel     = (chipselect == bus_pkg::cs_io);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      access_phase <= 1'b0;
    end else begin
      access_phase <= bus.start;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < sram_words; i++) begin
        sram[i] <= 32'h0;
      end
    end else if (bus.buswrite && sram_sel) begin
      sram[sram_index] <= bus.write_data;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 8; i++) begin
        io_regs[i] <= 32'h0;
      end
    end else if (bus.buswrite && io_sel) begin
      io_regs[io_index] <= bus.write_data;
    end
  end

  // sampled at the end of PRE, seen by the mmu in POST
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      read_data <= 32'h0;
    end else if (access_phase && !bus.buswrite) begin
      if (sram_sel) begin
        read_data <= sram[sram_index];
      end else if (io_sel) begin
        read_data <= io_regs[io_index];
      end else begin
        read_data <= 32'h0;
      end
    end
  end

  assert property (@(posedge clock) disable iff (!reset_n)
    bus.buswrite |-> chipselect != bus_pkg::cs_none);
  assert property (@(posedge clock) disable iff (!reset_n)
    bus.buswrite |-> access_phase);  // writes land one cycle after start

endmodule

// ==== design/bus_subsystem.sv ====
`timescale 1ns/10ps

module bus_subsystem #(
  parameter int fifo_depth = 4,
  parameter int sram_words = 64
) (
  input  logic                   clock,
  input  logic                   reset_n,
  input  logic                   push,
  input  bus_pkg::bus_request_t  request,
  output logic                   full,
  output logic                   buswait,
  output logic                   response_valid,
  output bus_pkg::bus_response_t response
);

  bus_pkg::bus_request_t head;
  logic                  present;
  logic                  pop;
  bus_pkg::chip_select_t chipselect;
  bus_pkg::bus_cycle_t   bus;
  logic [31:0]           read_data;

  request_fifo #(
    .fifo_depth (fifo_depth)
  ) request_fifo_inst (
    .clock   (clock),
    .reset_n (reset_n),
    .push    (push),
    .request (request),
    .pop     (pop),
    .head    (head),
    .present (present),
    .full    (full)
  );

  mmu mmu_inst (
    .clock          (clock),
    .reset_n        (reset_n),
    .head           (head),
    .present        (present),
    .read_data      (read_data),
    .pop            (pop),
    .chipselect     (chipselect),
    .bus            (bus),
    .buswait        (buswait),
    .response_valid (response_valid),
    .response       (response)
  );

  memory_targets #(
    .sram_words (sram_words)
  ) memory_targets_inst (
    .clock      (clock),
    .reset_n    (reset_n),
    .chipselect (chipselect),
    .bus        (bus),
    .read_data  (read_data)
  );

endmodule

// ==== testbench/tb_bus_subsystem.sv ====
`timescale 1ns/10ps

module tb_bus_subsystem;

  localparam int fifo_depth     = 4;
  localparam int sram_words     = 64;
  localparam int max_records    = 64;
  localparam int record_words   = 6;
  localparam int timeout_cycles = 20;

  // columns of one pattern record
  localparam int group_col        = 0;
  localparam int op_col           = 1;
  localparam int address_col      = 2;
  localparam int write_data_col   = 3;
  localparam int expect_data_col  = 4;
  localparam int expect_fault_col = 5;

  logic                   clock;
  logic                   reset_n;
  logic                   push;
  bus_pkg::bus_request_t  request;
  logic                   full;
  logic                   buswait;
  logic                   response_valid;
  bus_pkg::bus_response_t response;

  logic [31:0]            pattern_words [max_records*record_words];  // unread entries stay x
  bus_pkg::bus_response_t received [$];

  bus_subsystem #(
    .fifo_depth (fifo_depth),
    .sram_words (sram_words)
  ) bus_subsystem_inst (
    .clock          (clock),
    .reset_n        (reset_n),
    .push           (push),
    .request        (request),
    .full           (full),
    .buswait        (buswait),
    .response_valid (response_valid),
    .response       (response)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // responses kept in arrival order
  always @(negedge clock) begin
    if (response_valid) begin
      received.push_back(response);
    end
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                  $time, name, actual, expected));
    end
  endtask

  function automatic logic [31:0] field(input int r, input int col);
    return pattern_words[r*record_words + col];
  endfunction

  function automatic bus_pkg::bus_request_t make_request(input int r);
    bus_pkg::bus_request_t req;
    req.address    = field(r, address_col);
    req.write_data = field(r, write_data_col);
    req.write      = (field(r, op_col) == 32'h1);
    return req;
  endfunction

  task automatic take_response(output bus_pkg::bus_response_t got);
    int waited;
    waited = 0;
    while (received.size() == 0) begin
      if (waited == timeout_cycles) begin
        stop_with_failure("timed out waiting for a response pulse");
      end
      @(negedge clock);
      waited++;
    end
    got = received.pop_front();
  endtask

  task automatic check_response(input int r);
    bus_pkg::bus_response_t got;
    take_response(got);
    compare("response.read_data", got.read_data, field(r, expect_data_col));
    compare("response.fault", {30'b0, got.fault}, field(r, expect_fault_col));
  endtask

  // lone access from an idle system, response exactly 4 cycles after the push edge
  task automatic run_single(input int r);
    for (int cycle = 0; cycle < 6; cycle++) begin
      @(posedge clock);
      push <= (cycle == 0);
      if (cycle == 0) begin
        request <= make_request(r);
      end
      @(negedge clock);
      compare("response_valid", response_valid, cycle == 4);
      compare("buswait", buswait, cycle != 4);
    end
    check_response(r);
  endtask

  // back to back pushes, responses must keep push order
  task automatic run_group(input int r, input int n);
    if (n > fifo_depth) begin
      stop_with_failure("a pattern group holds more requests than the queue");
    end
    for (int i = 0; i < n; i++) begin
      @(posedge clock);
      push    <= 1'b1;
      request <= make_request(r + i);
    end
    @(posedge clock);
    push <= 1'b0;
    @(negedge clock);
    if (n == fifo_depth) begin
      compare("full", full, 1'b1);
    end
    for (int i = 0; i < n; i++) begin
      check_response(r + i);
    end
  endtask

  initial begin
    int r;
    int n;
    logic [31:0] group;
    push    = 1'b0;
    request = '0;
    reset_n = 1'b0;
    $readmemh("testbench/bus_patterns.hex", pattern_words);
    repeat (2) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
    compare("full", full, 1'b0);
    compare("buswait", buswait, 1'b1);
    compare("response_valid", response_valid, 1'b0);
    if ($isunknown(field(0, group_col))) begin
      stop_with_failure("no records read from testbench/bus_patterns.hex");
    end
    r = 0;
    while (r < max_records && !$isunknown(field(r, group_col))) begin
      group = field(r, group_col);
      if (group == 32'h0) begin
        run_single(r);
        r++;
      end else begin
        n = 0;
        while (r + n < max_records && field(r + n, group_col) === group) begin
          n++;
        end
        run_group(r, n);
        r += n;
      end
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== testbench/bus_patterns.hex ====
// group op address write_data read_data fault (group 0 single, same nonzero value back to back)
// op 1 = write; fault 0 none, 1 bus, 2 page, 3 write
// ssram, 0x110 aliases 0x010
0 1 00000010 11111111 00000000 0
0 1 00000014 22222222 00000000 0
0 1 003ffffc 33333333 00000000 0
0 0 00000010 00000000 11111111 0
0 0 00000014 00000000 22222222 0
0 0 003ffffc 00000000 33333333 0
0 1 00000110 44444444 00000000 0
0 0 00000010 00000000 44444444 0
0 0 00000110 00000000 44444444 0
0 0 00000020 00000000 00000000 0
// io registers, then regions with no model
0 1 00800800 a0a0a0a0 00000000 0
0 1 0080081c b1b1b1b1 00000000 0
0 1 00800804 c2c2c2c2 00000000 0
0 0 00800800 00000000 a0a0a0a0 0
0 0 0080081c 00000000 b1b1b1b1 0
0 0 00800804 00000000 c2c2c2c2 0
0 0 00800808 00000000 00000000 0
0 0 c0000000 00000000 00000000 0
0 0 e0000100 00000000 00000000 0
0 0 00800000 00000000 00000000 0
0 0 ffff0000 00000000 00000000 0
0 0 ffffffc0 00000000 00000000 0
// faults, then words the faulted writes would have hit
0 0 00000012 00000000 00000000 1
0 1 00000016 55555555 00000000 1
0 0 00400000 00000000 00000000 2
0 0 00400002 00000000 00000000 1
0 1 ffff0010 66666666 00000000 3
0 1 fffffffc 77777777 00000000 3
0 1 ffffffc2 88888888 00000000 1
0 0 00000014 00000000 22222222 0
0 0 00000010 00000000 44444444 0
// two queue-filling groups
1 1 00000030 aaaa0001 00000000 0
1 1 00000034 aaaa0002 00000000 0
1 0 00000030 00000000 aaaa0001 0
1 0 00000034 00000000 aaaa0002 0
2 1 00800810 d3d3d3d3 00000000 0
2 0 00800810 00000000 d3d3d3d3 0
2 0 00000110 00000000 44444444 0
2 0 00400000 00000000 00000000 2

// ==== src.f ====
design/bus_pkg.sv
design/request_fifo.sv
design/mmu.sv
design/memory_targets.sv
design/bus_subsystem.sv
testbench/tb_bus_subsystem.sv

// ==== Bender.yml ====
package:
  name: bus_subsystem

sources:
  - design/bus_pkg.sv
  - design/request_fifo.sv
  - design/mmu.sv
  - design/memory_targets.sv
  - design/bus_subsystem.sv
  - target: test
    files:
      - testbench/tb_bus_subsystem.sv
